// ==== font_ram.sv ====
// 8x8 font memory
`timescale 1ns/1ps

module font_ram (
    input  logic                             clk,
    input  logic                             we_i,
    input  logic [video_pkg::FONT_ADDR_W-1:0] waddr_i,
    input  logic [7:0]                       wdata_i,
    input  logic [video_pkg::FONT_ADDR_W-1:0] raddr_i,
    output logic [7:0]                       rdata_o
);
    import video_pkg::*;

    logic [7:0] mem [2**FONT_ADDR_W];              // 256 glyphs x 8 rows

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];                   // one clock read latency
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_video -f src.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

// ==== src.f ====
video_pkg.sv
video_timing.sv
video_regs.sv
font_ram.sv
text_fetch.sv
video_gen_top.sv
video_checker.sv
tb_clk_gen.sv
tb_monitor.sv
tb_video.sv

// ==== tb_clk_gen.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);
    localparam int HALF_NS = 20;                   // 40 ns period

    initial clk_o = 1'b0;

    always #(HALF_NS) clk_o = ~clk_o;

endmodule

// ==== tb_monitor.sv ====
// pixel and raster monitor
`timescale 1ns/1ps

module tb_monitor (
    input logic                       clk,
    input logic                       reset_i,
    input logic [video_pkg::PAL_W-1:0] pal_index_i,
    input logic                       hsync_i,
    input logic                       vsync_i,
    input logic                       dv_de_i
);
    import video_pkg::*;

    int          x_pos = 0;
    int          y_pos = 0;
    int          frames_checked = 0;
    int          pix_errs = 0;
    int          hsync_errs = 0;               // sync pulse and period faults
    int          shape_errs = 0;               // display enable shape faults
    int          vs_starts = 0;
    logic        chk_on = 1'b0;                // checking a whole frame
    logic [15:0] act_start;                    // config of frame on screen
    logic [15:0] act_width;
    int          hs_len = 0;
    int          hs_period = 0;
    int          hs_starts = 0;
    int          vs_lines = 0;
    int          frame_lines = 0;
    int          de_run = 0;
    int          de_lines = 0;
    logic        hs_prev = 1'b0;
    logic        vs_prev = 1'b0;
    logic        de_prev = 1'b0;

    // pixel value straight from the tile, font and color rules
    function automatic logic [PAL_W-1:0] expected_pixel(int x, int y,
                                                        logic [15:0] start,
                                                        logic [15:0] width);
        logic [15:0] addr;
        logic [15:0] w;
        logic [7:0]  g;
        addr = start + 16'(y / FONT_HEIGHT) * width + 16'(x / TILE_WIDTH);
        w    = tb_video.vram[addr];
        g    = tb_video.font_shadow[{w[7:0], 3'(y % FONT_HEIGHT)}];
        return g[7 - (x % TILE_WIDTH)] ? w[11:8] : w[15:12];   // fg on set bit
    endfunction

    // sampled on the rising edge, outputs hold last cycle's values
    always @(posedge clk) begin : pixel_compare
        logic [PAL_W-1:0] exp_pix;
        if (reset_i) begin
            x_pos  = 0;
            y_pos  = 0;
            chk_on = 1'b0;
        end else if (dv_de_i) begin
            if (x_pos == 0 && y_pos == 0) begin
                chk_on    = tb_video.check_en;     // only whole frames
                act_start = tb_video.cfg_start;
                act_width = tb_video.cfg_width;
            end
            if (chk_on) begin
                exp_pix = expected_pixel(x_pos, y_pos, act_start, act_width);
                if (pal_index_i !== exp_pix) begin
                    pix_errs++;
                    if (pix_errs <= 10) begin
                        $display("Fail t=%0t pal_index_o x=%0d y=%0d expected %h got %h",
                                 $time, x_pos, y_pos, exp_pix, pal_index_i);
                    end
                end
            end
            x_pos++;
            if (x_pos == int'(H_VISIBLE)) begin
                x_pos = 0;
                y_pos++;
                if (y_pos == int'(V_VISIBLE)) begin
                    y_pos = 0;
                    if (chk_on) frames_checked++;
                end
            end
        end
    end

    always @(posedge clk) begin : raster_compare
        logic hs_act;
        logic vs_act;
        hs_act = (hsync_i == H_SYNC_POLARITY);
        vs_act = (vsync_i == V_SYNC_POLARITY);
        if (!reset_i) begin
            hs_period++;
            if (hs_act && !hs_prev) begin      // hsync leading edge
                if (hs_starts > 0 && hs_period != int'(H_TOTAL)) begin
                    hsync_errs++;
                    $display("Fail t=%0t hsync_o period expected %0d got %0d",
                             $time, H_TOTAL, hs_period);
                end
                hs_period = 0;
                hs_starts++;
                frame_lines++;
                if (vs_act) vs_lines++;
            end
            if (hs_act) begin
                hs_len++;
            end else if (hs_prev) begin
                if (hs_len != int'(H_SYNC_PULSE)) begin
                    hsync_errs++;
                    $display("Fail t=%0t hsync_o width expected %0d got %0d",
                             $time, H_SYNC_PULSE, hs_len);
                end
                hs_len = 0;
            end
            if (vs_act && !vs_prev) begin      // new frame at vsync
                if (vs_starts > 0 && frame_lines != int'(V_TOTAL)) begin
                    hsync_errs++;
                    $display("Fail t=%0t vsync_o period lines expected %0d got %0d",
                             $time, V_TOTAL, frame_lines);
                end
                if (de_lines != int'(V_VISIBLE)) begin
                    shape_errs++;
                    $display("Fail t=%0t dv_de_o lines expected %0d got %0d",
                             $time, V_VISIBLE, de_lines);
                end
                frame_lines = 0;
                de_lines    = 0;
                vs_starts++;
            end else if (!vs_act && vs_prev) begin
                if (vs_lines != int'(V_SYNC_PULSE)) begin
                    hsync_errs++;
                    $display("Fail t=%0t vsync_o lines expected %0d got %0d",
                             $time, V_SYNC_PULSE, vs_lines);
                end
                vs_lines = 0;
            end
            if (dv_de_i) begin
                de_run++;
            end else if (de_prev) begin
                if (de_run != int'(H_VISIBLE)) begin
                    shape_errs++;
                    $display("Fail t=%0t dv_de_o run expected %0d got %0d",
                             $time, H_VISIBLE, de_run);
                end
                de_run = 0;
                de_lines++;
            end
        end
        hs_prev = hs_act && !reset_i;
        vs_prev = vs_act && !reset_i;
        de_prev = dv_de_i && !reset_i;
    end

endmodule

// ==== tb_video.sv ====
// text video testbench
`timescale 1ns/1ps

module tb_video;
    import video_pkg::*;

    localparam int     CLK_NS     = 40;
    localparam int     FONT_BYTES = 2**FONT_ADDR_W;
    localparam longint WATCHDOG_NS = longint'(2 * (FONT_BYTES * 3 +
                                     6 * int'(H_TOTAL) * int'(V_TOTAL)) * CLK_NS);

    logic                   clk;
    logic                   reset_i;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [WB_ADDR_W-1:0]   wb_adr;
    logic [WB_DATA_W-1:0]   wb_dat_w;
    logic                   wb_ack;
    logic [WB_DATA_W-1:0]   wb_dat_r;
    logic                   vram_sel;
    logic [VRAM_ADDR_W-1:0] vram_addr;
    logic [15:0]            vram_data;
    logic [PAL_W-1:0]       pal_index;
    logic                   hsync;
    logic                   vsync;
    logic                   dv_de;

    logic [15:0] vram [0:65535];                // external text memory
    logic [7:0]  font_shadow [0:FONT_BYTES-1];  // copy of what went over the bus
    logic [15:0] cfg_start;                     // last written config
    logic [15:0] cfg_width;
    logic        check_en;
    int          bus_errs;
    int          vram_errs;
    int          vram_reads;                    // tile word reads this frame
    int          tests_pass;
    int          tests_fail;
    logic        sel_q;
    logic [15:0] addr_q;
    logic        vs_q;

    tb_clk_gen u_clk (.clk_o(clk));

    video_gen_top uut (
        .clk(clk), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r),
        .vram_sel_o(vram_sel), .vram_addr_o(vram_addr), .vram_data_i(vram_data),
        .pal_index_o(pal_index), .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    tb_monitor mon (
        .clk(clk), .reset_i(reset_i), .pal_index_i(pal_index),
        .hsync_i(hsync), .vsync_i(vsync), .dv_de_i(dv_de)
    );

    // vram answers in the cycle after the select cycle
    always @(negedge clk) begin
        if (sel_q) vram_data <= vram[addr_q];
        sel_q  <= vram_sel;
        addr_q <= vram_addr;
    end

    // every visible line reads each of its tile words once
    always @(negedge clk) begin : vram_read_count
        if (reset_i) begin
            vram_reads = 0;
            vs_q       = 1'b0;
        end else begin
            if (vram_sel) vram_reads++;
            if (vsync == V_SYNC_POLARITY && !vs_q) begin
                if (vram_reads != TILES_WIDE * TILES_HIGH * FONT_HEIGHT) begin
                    vram_errs++;
                    $display("Fail t=%0t vram_sel_o reads per frame expected %0d got %0d",
                             $time, TILES_WIDE * TILES_HIGH * FONT_HEIGHT, vram_reads);
                end
                vram_reads = 0;
            end
            vs_q = (vsync == V_SYNC_POLARITY);
        end
    end

    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
        int lat;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        lat      = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!wb_ack && lat < 16);
        if (!wb_ack) begin
            bus_errs++;
            $display("bus cycle to address %h was never acknowledged", adr);
        end else if (lat != 1) begin
            bus_errs++;
            $display("Fail t=%0t wb_ack_o latency expected 1 got %0d", $time, lat);
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: fail with %0d errors", name, errs);
        end
    endtask

    task automatic check_read(input logic [WB_ADDR_W-1:0] adr, input logic [15:0] exp,
                              inout int errs);
        logic [15:0] rd;
        bus_cycle(1'b0, adr, 16'h0000, rd);
        if (rd !== exp) begin
            errs++;
            $display("Fail t=%0t wb_dat_o expected %h got %h", $time, exp, rd);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [15:0] rd;
        int          errs;
        int          e0;
        int          f0;
        void'($urandom(40));
        reset_i = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        vram_data = '0;
        sel_q = 1'b0;
        addr_q = '0;
        check_en = 1'b0;
        cfg_start = 16'h0000;
        cfg_width = 16'(TILES_WIDE);
        bus_errs = 0;
        vram_errs = 0;
        tests_pass = 0;
        tests_fail = 0;
        for (int i = 0; i < 65536; i++) vram[i] = 16'($urandom);
        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        errs = 0;                               // register access
        bus_cycle(1'b1, REG_DISPSTART, 16'h1234, rd);
        bus_cycle(1'b1, REG_DISPWIDTH, 16'h0021, rd);
        check_read(REG_DISPSTART, 16'h1234, errs);
        check_read(REG_DISPWIDTH, 16'h0021, errs);
        bus_cycle(1'b1, REG_DISPSTART, 16'h0000, rd);
        bus_cycle(1'b1, REG_DISPWIDTH, 16'(TILES_WIDE), rd);
        report_test("register access", errs + bus_errs);

        for (int i = 0; i < FONT_BYTES; i++) begin
            font_shadow[i] = 8'($urandom);
            bus_cycle(1'b1, FONT_BASE + WB_ADDR_W'(i), {8'h00, font_shadow[i]}, rd);
        end
        check_en = 1'b1;
        e0 = mon.pix_errs;
        while (mon.frames_checked < 1) @(negedge clk);
        report_test("pixel content at reset values", mon.pix_errs - e0);

        e0 = mon.pix_errs;
        while (mon.y_pos != 10) @(negedge clk);   // middle of the visible area
        f0 = mon.frames_checked;
        bus_cycle(1'b1, REG_DISPSTART, 16'h0105, rd);
        bus_cycle(1'b1, REG_DISPWIDTH, 16'd13, rd);
        cfg_start = 16'h0105;
        cfg_width = 16'd13;
        while (mon.frames_checked < f0 + 2) @(negedge clk);
        check_en = 1'b0;                        // no frame left half checked
        report_test("new registers from next frame", mon.pix_errs - e0);

        errs = 0;
        while (vsync !== V_SYNC_POLARITY) @(negedge clk);
        bus_cycle(1'b0, REG_SCANLINE, 16'h0000, rd);
        if (!rd[15] || rd[10:0] < V_VISIBLE) begin
            errs++;
            $display("Fail t=%0t wb_dat_o scanline expected blank line got %h", $time, rd);
        end
        report_test("scanline status", errs);

        report_test("line timing", mon.hsync_errs + ((mon.vs_starts < 2) ? 1 : 0));
        report_test("frame shape", mon.shape_errs);
        report_test("vram reads", vram_errs);

        $display("tests passed %0d failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0 && bus_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== text_fetch.sv ====
// text tile fetch and pixel shifter
`timescale 1ns/1ps

module text_fetch (
    input  logic                             clk,
    input  logic                             reset_i,
    input  video_pkg::video_state_t          h_state_i,
    input  video_pkg::video_state_t          v_state_i,
    input  logic [video_pkg::COUNT_W-1:0]     h_count_i,
    input  logic                             line_end_i,
    input  logic                             frame_end_i,
    input  logic [15:0]                      disp_start_i,
    input  logic [15:0]                      line_width_i,
    output logic                             vram_sel_o,
    output logic [video_pkg::VRAM_ADDR_W-1:0] vram_addr_o,
    input  logic [15:0]                      vram_data_i,
    output logic [video_pkg::FONT_ADDR_W-1:0] font_raddr_o,
    input  logic [7:0]                       font_rdata_i,
    output logic [video_pkg::PAL_W-1:0]       pal_index_o
);
    import video_pkg::*;

    localparam logic [COUNT_W-1:0] FETCH_START = H_TOTAL - H_VISIBLE - COUNT_W'(FETCH_LEAD);
    localparam logic [COUNT_W-1:0] FETCH_STOP  = H_TOTAL - COUNT_W'(TILE_WIDTH);

    logic [VRAM_ADDR_W-1:0] text_addr;             // next tile word to fetch
    logic [VRAM_ADDR_W-1:0] line_addr;             // first word of current tile row
    logic [15:0]            width_q;               // line width for this frame
    logic [2:0]             tile_row;              // glyph row of current line
    logic                   fetch_win;
    logic [2:0]             phase;                 // position in eight clock tile slot
    logic [15:0]            word_save;             // tile+color word in flight
    logic [7:0]             shifter;               // glyph bits, msb is current pixel
    logic [2*PAL_W-1:0]     colors;                // {bg, fg} of tile on screen
    logic [PAL_W-1:0]       pixel;

    // slots run from FETCH_LEAD before pixel 0 up to the last tile
    assign fetch_win = (v_state_i == STATE_VISIBLE) &&
                       (((h_state_i == STATE_POST_SYNC) && (h_count_i >= FETCH_START)) ||
                        ((h_state_i == STATE_VISIBLE) && (h_count_i < FETCH_STOP)));
    assign phase     = h_count_i[2:0] - FETCH_START[2:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            text_addr  <= '0;
            line_addr  <= '0;
            width_q    <= 16'(TILES_WIDE);
            tile_row   <= '0;
        end else begin
            vram_sel_o <= 1'b0;
            if (fetch_win && phase == 3'd0) begin
                vram_sel_o <= 1'b1;                // read tile word
                text_addr  <= text_addr + 1'b1;
            end
            if (line_end_i) begin
                if (tile_row == 3'(FONT_HEIGHT - 1)) begin
                    tile_row  <= '0;               // next row of tiles
                    line_addr <= line_addr + width_q;
                    text_addr <= line_addr + width_q;
                end else begin
                    tile_row  <= tile_row + 1'b1;
                    text_addr <= line_addr;        // same tiles, next glyph row
                end
            end
            if (frame_end_i) begin
                width_q   <= line_width_i;         // new values only between frames
                line_addr <= disp_start_i;
                text_addr <= disp_start_i;
                tile_row  <= '0;
            end
        end
    end

    // payload pipeline
    always_ff @(posedge clk) begin
        if (fetch_win && phase == 3'd0) begin
            vram_addr_o <= text_addr;
        end
        if (fetch_win && phase == 3'd2) begin
            word_save    <= vram_data_i;           // vram data valid one clock after sel
            font_raddr_o <= {vram_data_i[7:0], tile_row};
        end
        if (fetch_win && phase == 3'd7) begin
            shifter <= font_rdata_i;               // takes effect at the tile boundary
            colors  <= {word_save[15:12], word_save[11:8]};
        end else begin
            shifter <= {shifter[6:0], 1'b0};
        end
        pal_index_o <= pixel;                      // lines up with dv_de_o register
    end

    assign pixel = shifter[7] ? colors[PAL_W-1:0] : colors[2*PAL_W-1:PAL_W];

endmodule

// ==== video_checker.sv ====
// sync and bus assertions
`timescale 1ns/1ps

module video_checker (
    input logic clk,
    input logic reset_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic hsync_o,
    input logic vsync_o,
    input logic dv_de_o
);
    import video_pkg::*;

    logic               hs_act;
    logic               vs_act;
    logic [COUNT_W-1:0] hs_run;                    // clocks of active hsync so far

    assign hs_act = (hsync_o == H_SYNC_POLARITY);
    assign vs_act = (vsync_o == V_SYNC_POLARITY);

    always_ff @(posedge clk) begin
        if (reset_i || !hs_act) begin
            hs_run <= '0;
        end else begin
            hs_run <= hs_run + 1'b1;
        end
    end

    // ack only answers a strobe that has not been acked yet
    ack_single: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |-> $past(wb_stb_i && !wb_ack_o))
        else $error("wb_ack_o high without a fresh strobe or for two cycles");

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $fell(hs_act) |-> (hs_run == H_SYNC_PULSE))
        else $error("hsync_o pulse width differs from H_SYNC_PULSE");

    hsync_bound: assert property (@(posedge clk) disable iff (reset_i)
        hs_run <= H_SYNC_PULSE)
        else $error("hsync_o active too long");

    de_in_blank: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> (!hs_act && !vs_act))
        else $error("dv_de_o high during sync");

endmodule

bind video_gen_top video_checker u_checker (.*);

// ==== video_gen_top.sv ====
// text video generator top
`timescale 1ns/1ps

module video_gen_top (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [video_pkg::WB_ADDR_W-1:0]   wb_adr_i,
    input  logic [video_pkg::WB_DATA_W-1:0]   wb_dat_i,
    output logic                             wb_ack_o,
    output logic [video_pkg::WB_DATA_W-1:0]   wb_dat_o,
    output logic                             vram_sel_o,
    output logic [video_pkg::VRAM_ADDR_W-1:0] vram_addr_o,
    input  logic [15:0]                      vram_data_i,
    output logic [video_pkg::PAL_W-1:0]       pal_index_o,
    output logic                             hsync_o,
    output logic                             vsync_o,
    output logic                             dv_de_o
);
    import video_pkg::*;

    video_state_t           h_state;
    video_state_t           v_state;
    logic [COUNT_W-1:0]     h_count;
    logic [COUNT_W-1:0]     v_count;
    logic                   line_end;
    logic                   frame_end;
    logic [15:0]            disp_start;
    logic [15:0]            line_width;
    logic                   font_we;               // bus side font port
    logic [FONT_ADDR_W-1:0] font_waddr;
    logic [7:0]             font_wdata;
    logic [FONT_ADDR_W-1:0] font_raddr;            // fetch side font port
    logic [7:0]             font_rdata;

    video_timing u_timing (
        .clk(clk), .reset_i(reset_i),
        .h_state_o(h_state), .v_state_o(v_state),
        .h_count_o(h_count), .v_count_o(v_count),
        .line_end_o(line_end), .frame_end_o(frame_end),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    video_regs u_regs (
        .clk(clk), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .v_state_i(v_state), .h_state_i(h_state), .v_count_i(v_count),
        .disp_start_o(disp_start), .line_width_o(line_width),
        .font_we_o(font_we), .font_waddr_o(font_waddr), .font_wdata_o(font_wdata)
    );

    font_ram u_font (
        .clk(clk), .we_i(font_we), .waddr_i(font_waddr), .wdata_i(font_wdata),
        .raddr_i(font_raddr), .rdata_o(font_rdata)
    );

    text_fetch u_fetch (
        .clk(clk), .reset_i(reset_i),
        .h_state_i(h_state), .v_state_i(v_state), .h_count_i(h_count),
        .line_end_i(line_end), .frame_end_i(frame_end),
        .disp_start_i(disp_start), .line_width_i(line_width),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .font_raddr_o(font_raddr), .font_rdata_i(font_rdata),
        .pal_index_o(pal_index_o)
    );

endmodule

// ==== video_pkg.sv ====
// text video shared definitions
package video_pkg;

    localparam int COUNT_W     = 11;              // raster counter width
    localparam int VRAM_ADDR_W = 16;              // vram word address
    localparam int FONT_ADDR_W = 11;              // tile index 8b + tile row 3b
    localparam int WB_ADDR_W   = 12;
    localparam int WB_DATA_W   = 16;
    localparam int PAL_W       = 4;               // palette index

    // simulation sized raster
    localparam logic [COUNT_W-1:0] H_VISIBLE     = 11'd64;
    localparam logic [COUNT_W-1:0] H_FRONT_PORCH = 11'd4;
    localparam logic [COUNT_W-1:0] H_SYNC_PULSE  = 11'd8;
    localparam logic [COUNT_W-1:0] H_BACK_PORCH  = 11'd12;
    localparam logic [COUNT_W-1:0] H_TOTAL       = 11'd88;
    localparam logic [COUNT_W-1:0] V_VISIBLE     = 11'd24;
    localparam logic [COUNT_W-1:0] V_FRONT_PORCH = 11'd2;
    localparam logic [COUNT_W-1:0] V_SYNC_PULSE  = 11'd2;
    localparam logic [COUNT_W-1:0] V_BACK_PORCH  = 11'd4;
    localparam logic [COUNT_W-1:0] V_TOTAL       = 11'd32;

    localparam logic H_SYNC_POLARITY = 1'b0;      // active low
    localparam logic V_SYNC_POLARITY = 1'b0;      // active low

    localparam int FONT_HEIGHT = 8;               // fixed 8x8 glyphs
    localparam int TILE_WIDTH  = 8;
    localparam int TILES_WIDE  = 8;               // also the reset line width
    localparam int TILES_HIGH  = 3;
    localparam int FETCH_LEAD  = 8;               // fetch starts one tile ahead of pixel 0

    localparam logic [WB_ADDR_W-1:0] REG_DISPSTART = 12'h000;  // vram addr of first tile
    localparam logic [WB_ADDR_W-1:0] REG_DISPWIDTH = 12'h001;  // words per tile row
    localparam logic [WB_ADDR_W-1:0] REG_SCANLINE  = 12'h002;  // read only status
    localparam logic [WB_ADDR_W-1:0] FONT_BASE     = 12'h800;  // font ram window

    typedef enum logic [1:0] {
        STATE_PRE_SYNC  = 2'b00,
        STATE_SYNC      = 2'b01,
        STATE_POST_SYNC = 2'b10,
        STATE_VISIBLE   = 2'b11
    } video_state_t;

endpackage

// ==== video_regs.sv ====
// wishbone control registers
`timescale 1ns/1ps

module video_regs (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [video_pkg::WB_ADDR_W-1:0]   wb_adr_i,
    input  logic [video_pkg::WB_DATA_W-1:0]   wb_dat_i,
    output logic                             wb_ack_o,
    output logic [video_pkg::WB_DATA_W-1:0]   wb_dat_o,
    input  video_pkg::video_state_t          v_state_i,
    input  video_pkg::video_state_t          h_state_i,
    input  logic [video_pkg::COUNT_W-1:0]     v_count_i,
    output logic [15:0]                      disp_start_o,
    output logic [15:0]                      line_width_o,
    output logic                             font_we_o,
    output logic [video_pkg::FONT_ADDR_W-1:0] font_waddr_o,
    output logic [7:0]                       font_wdata_o
);
    import video_pkg::*;

    logic                 bus_req;                 // new cycle, ack not yet given
    logic                 is_font;                 // address in font window
    logic [WB_ADDR_W-1:0] font_offset;
    logic [WB_DATA_W-1:0] rd_data;

    assign bus_req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign is_font     = (wb_adr_i >= FONT_BASE);
    assign font_offset = wb_adr_i - FONT_BASE;

    // font write lands on the same edge that raises ack
    assign font_we_o    = bus_req && wb_we_i && is_font;
    assign font_waddr_o = font_offset[FONT_ADDR_W-1:0];
    assign font_wdata_o = wb_dat_i[7:0];         // low byte only

    always_comb begin
        case (wb_adr_i)
            REG_DISPSTART: rd_data = disp_start_o;
            REG_DISPWIDTH: rd_data = line_width_o;
            REG_SCANLINE:  rd_data = {(v_state_i != STATE_VISIBLE),   // vertical blank
                                      (h_state_i != STATE_VISIBLE),   // horizontal blank
                                      3'b000, v_count_i};
            default:       rd_data = '0;         // unused and font addresses
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o     <= 1'b0;
            disp_start_o <= 16'h0000;
            line_width_o <= 16'(TILES_WIDE);
        end else begin
            wb_ack_o <= bus_req;                   // one cycle ack
            if (bus_req && wb_we_i) begin
                case (wb_adr_i)
                    REG_DISPSTART: disp_start_o <= wb_dat_i;
                    REG_DISPWIDTH: line_width_o <= wb_dat_i;
                    default: ;                     // scanline is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req) begin
            wb_dat_o <= rd_data;                   // valid with ack
        end
    end

endmodule

// ==== video_timing.sv ====
// raster sync timing
`timescale 1ns/1ps

module video_timing (
    input  logic                         clk,
    input  logic                         reset_i,
    output video_pkg::video_state_t      h_state_o,
    output video_pkg::video_state_t      v_state_o,
    output logic [video_pkg::COUNT_W-1:0] h_count_o,
    output logic [video_pkg::COUNT_W-1:0] v_count_o,
    output logic                         line_end_o,   // last pixel clock of a line
    output logic                         frame_end_o,  // last pixel clock of a frame
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         dv_de_o
);
    import video_pkg::*;

    video_state_t       h_state;
    video_state_t       v_state;
    logic [COUNT_W-1:0] h_count;
    logic [COUNT_W-1:0] v_count;
    logic [COUNT_W-1:0] h_limit;                   // count where h state advances
    logic [COUNT_W-1:0] v_limit;                   // line where v state advances
    logic               h_step;
    logic               v_step;

    // blanking is on the left of a line, visible lines come first in a frame
    always_comb begin
        case (h_state)
            STATE_PRE_SYNC:  h_limit = H_FRONT_PORCH - 1'b1;
            STATE_SYNC:      h_limit = H_FRONT_PORCH + H_SYNC_PULSE - 1'b1;
            STATE_POST_SYNC: h_limit = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH - 1'b1;
            default:         h_limit = H_TOTAL - 1'b1;
        endcase
    end

    always_comb begin
        case (v_state)
            STATE_VISIBLE:   v_limit = V_VISIBLE - 1'b1;
            STATE_PRE_SYNC:  v_limit = V_VISIBLE + V_FRONT_PORCH - 1'b1;
            STATE_SYNC:      v_limit = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1'b1;
            default:         v_limit = V_TOTAL - 1'b1;
        endcase
    end

    assign h_step      = (h_count == h_limit);
    assign line_end_o  = h_step && (h_state == STATE_VISIBLE);
    assign v_step      = line_end_o && (v_count == v_limit);
    assign frame_end_o = v_step && (v_state == STATE_POST_SYNC);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= STATE_PRE_SYNC;
            v_state <= STATE_VISIBLE;
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~H_SYNC_POLARITY;           // inactive level
            vsync_o <= ~V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            h_count <= line_end_o ? '0 : h_count + 1'b1;
            if (h_step) begin
                h_state <= video_state_t'(h_state + 2'd1); // wraps visible -> pre sync
            end
            if (line_end_o) begin
                v_count <= frame_end_o ? '0 : v_count + 1'b1;
            end
            if (v_step) begin
                v_state <= video_state_t'(v_state + 2'd1);
            end
            // outputs lag the state by one clock
            hsync_o <= (h_state == STATE_SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (v_state == STATE_SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o <= (h_state == STATE_VISIBLE) && (v_state == STATE_VISIBLE);
        end
    end

    assign h_state_o = h_state;
    assign v_state_o = v_state;
    assign h_count_o = h_count;
    assign v_count_o = v_count;

endmodule
